// ==== all.f ====
verilog/mps_pkg.sv
verilog/mps_axil_regs.sv
verilog/mps_uart_port.sv
verilog/mps_irq_mux.sv
verilog/mps_top.sv
verif/mps_tb.sv

// ==== verif/mps_input.txt ====
# op port offset byte expected; port is decimal, the rest hex
# W: expected holds wstrb; R: read data; T: frame byte; I: interrupt level
W 0 0 a5 f
R 0 4 00 01
T 0 0 00 a5
R 0 4 00 00
W 1 0 3c f
T 1 0 00 3c
R 1 4 00 00
W 2 0 81 f
T 2 0 00 81
R 2 4 00 00
W 3 0 e7 f
T 3 0 00 e7
R 3 4 00 00
S 0 0 5a 00
R 0 4 00 02
R 0 0 00 5a
R 0 4 00 00
S 1 0 3c 00
S 1 0 c6 00
R 1 4 00 06
R 1 0 00 3c
R 1 4 00 00
W 3 8 02 f
W 3 0 c3 f
T 3 0 00 c3
R 3 4 00 02
R 3 0 00 c3
W 3 8 00 f
I 0 0 00 0
S 2 0 96 00
I 0 0 00 0
R 2 4 00 02
W 2 8 01 f
I 0 0 00 1
R 2 0 00 96
I 0 0 00 0
W 2 8 00 f
W 1 8 03 0
R 1 8 00 00
R 3 c 00 00
W 3 c 55 f
R 4 0 00 00
W 4 0 77 f
R 0 4 00 00
R 3 8 00 00

// ==== verif/mps_tb.sv ====
`timescale 1ns/1ps

module mps_tb import mps_pkg::*; ();

	localparam int WAIT_LIMIT = 1000; // Cycles per handshake or edge wait

	logic aclk;
	logic rstni;
	logic awvalid;
	logic awready;
	axi_addr_t awaddr;
	logic wvalid;
	logic wready;
	axi_data_t wdata;
	logic [3:0] wstrb;
	logic bvalid;
	logic bready;
	axi_resp_t bresp;
	logic arvalid;
	logic arready;
	axi_addr_t araddr;
	logic rvalid;
	logic rready;
	axi_data_t rdata;
	axi_resp_t rresp;
	logic intr_request;
	logic [PORT_NUM-1:0] rxd;
	logic [PORT_NUM-1:0] txd;

	int checks;
	int errors;
	logic timed_out;

	mps_top dut (
		.aclk(aclk),
		.rstni(rstni),
		.awvalid_i(awvalid),
		.awready_o(awready),
		.awaddr_i(awaddr),
		.wvalid_i(wvalid),
		.wready_o(wready),
		.wdata_i(wdata),
		.wstrb_i(wstrb),
		.bvalid_o(bvalid),
		.bready_i(bready),
		.bresp_o(bresp),
		.arvalid_i(arvalid),
		.arready_o(arready),
		.araddr_i(araddr),
		.rvalid_o(rvalid),
		.rready_i(rready),
		.rdata_o(rdata),
		.rresp_o(rresp),
		.intr_request_o(intr_request),
		.rxd_i(rxd),
		.txd_o(txd)
	);

	initial begin
		aclk = 1'b0;
		forever #4 aclk = ~aclk;
	end

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			errors++;
			$display("error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("timeout: %s", what);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge aclk);
	endtask

	// Port index at or past PORT_NUM, or the unused fourth register slot
	function automatic axi_resp_t expected_resp(input int port, input int offs);
		if (port >= PORT_NUM || offs >= 12)
			return RESP_SLVERR;
		return RESP_OKAY;
	endfunction

	task automatic axi_write(input int port, input int offs, input byte_t data,
		input logic [3:0] strb, output axi_resp_t resp);
		int n;
		logic accepted;
		resp = '0;
		awaddr = axi_addr_t'((port << PORT_STRIDE_LSB) + offs);
		wdata = {24'h0, data};
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		@(posedge aclk);
		while (!(awready && wready) && n < WAIT_LIMIT) begin // Seen just before the edge
			@(posedge aclk);
			n++;
		end
		accepted = awready && wready;
		@(negedge aclk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (!accepted) begin
			report_timeout("write address and data were never accepted");
		end else begin
			n = 0;
			while (!bvalid && n < WAIT_LIMIT) begin
				@(negedge aclk);
				n++;
			end
			if (!bvalid) begin
				report_timeout("no write response on the B channel");
			end else begin
				resp = bresp;
				bready = 1'b1;
				@(negedge aclk);
				bready = 1'b0;
			end
		end
	endtask

	task automatic axi_read(input int port, input int offs, input string name,
		output byte_t data, output axi_resp_t resp);
		int n;
		logic accepted;
		data = '0;
		resp = '0;
		araddr = axi_addr_t'((port << PORT_STRIDE_LSB) + offs);
		arvalid = 1'b1;
		n = 0;
		@(posedge aclk);
		while (!arready && n < WAIT_LIMIT) begin
			@(posedge aclk);
			n++;
		end
		accepted = arready;
		@(negedge aclk);
		arvalid = 1'b0;
		if (!accepted) begin
			report_timeout("read address was never accepted");
		end else begin
			n = 0;
			while (!rvalid && n < WAIT_LIMIT) begin
				@(negedge aclk);
				n++;
			end
			if (!rvalid) begin
				report_timeout("no read data on the R channel");
			end else begin
				data = rdata[7:0];
				resp = rresp;
				check_value({name, " rdata upper bytes"}, 0, rdata[31:8]);
				rready = 1'b1;
				@(negedge aclk);
				rready = 1'b0;
			end
		end
	endtask

	// Start bit, eight data bits LSB first, stop bit
	task automatic send_serial(input int port, input byte_t data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int b = 0; b < 10; b++) begin
			rxd[port] = frame[b];
			wait_cycles(BAUD_DIV);
		end
	endtask

	task automatic capture_frame(input int port, input string name, output byte_t data);
		int n;
		data = '0;
		n = 0;
		while (txd[port] && n < WAIT_LIMIT) begin // Line may already be low
			@(negedge aclk);
			n++;
		end
		if (txd[port]) begin
			report_timeout("no start bit on the serial line");
		end else begin
			wait_cycles(BAUD_DIV / 2); // Middle of the start bit
			check_value({name, " start bit"}, 0, txd[port]);
			for (int b = 0; b < 8; b++) begin
				wait_cycles(BAUD_DIV);
				data[b] = txd[port];
			end
			wait_cycles(BAUD_DIV);
			check_value({name, " stop bit"}, 1, txd[port]);
			wait_cycles(BAUD_DIV); // Past the end of the frame
		end
	endtask

	initial begin
		int fd;
		int code;
		int line_no;
		int ch;
		int port;
		int offs;
		int data;
		int expected;
		byte op;
		string name;
		byte_t got;
		axi_resp_t resp;
		checks = 0;
		errors = 0;
		timed_out = 1'b0;
		line_no = 0;
		rstni = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		rxd = '1; // Idle lines
		repeat (16) @(posedge aclk);
		@(negedge aclk);
		rstni = 1'b1;
		wait_cycles(2);
		fd = $fopen("verif/mps_input.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open the stimulus file verif/mps_input.txt");
		end else begin
			code = $fscanf(fd, " %c", op);
			while (code == 1 && !timed_out) begin
				line_no++;
				if (op == "#") begin
					ch = $fgetc(fd);
					while (ch != 10 && ch != -1)
						ch = $fgetc(fd);
				end else begin
					code = $fscanf(fd, "%d %h %h %h", port, offs, data, expected);
					name = $sformatf("%c p%0d +%0h line %0d", op, port, offs, line_no);
					if (code != 4) begin
						errors++;
						$display("stimulus line %0d is malformed", line_no);
					end else begin
						case (op)
							"W": begin
								axi_write(port, offs, data, expected, resp);
								if (!timed_out)
									check_value({name, " bresp"}, expected_resp(port, offs), resp);
							end
							"R": begin
								axi_read(port, offs, name, got, resp);
								if (!timed_out) begin
									check_value({name, " rresp"}, expected_resp(port, offs), resp);
									check_value({name, " rdata"}, expected, got);
								end
							end
							"S": send_serial(port, data);
							"T": begin
								capture_frame(port, name, got);
								if (!timed_out)
									check_value({name, " frame"}, expected, got);
							end
							"I": check_value({name, " intr_request"}, expected, intr_request);
							default: begin
								errors++;
								$display("unknown opcode %c on stimulus line %0d", op, line_no);
							end
						endcase
					end
				end
				code = $fscanf(fd, " %c", op);
			end
			$fclose(fd);
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== verilog/mps_axil_regs.sv ====
`timescale 1ns/1ps

module mps_axil_regs import mps_pkg::*; (
	input aclk,
	input rstni,

	input awvalid_i,
	output logic awready_o,
	input axi_addr_t awaddr_i,
	input wvalid_i,
	output logic wready_o,
	input axi_data_t wdata_i,
	input [3:0] wstrb_i,
	output logic bvalid_o,
	input bready_i,
	output axi_resp_t bresp_o,
	input arvalid_i,
	output logic arready_o,
	input axi_addr_t araddr_i,
	output logic rvalid_o,
	input rready_i,
	output axi_data_t rdata_o,
	output axi_resp_t rresp_o,

	output logic [PORT_NUM-1:0] wr_stb_o,
	output logic [PORT_NUM-1:0] rd_stb_o,
	output reg_idx_t reg_sel_o,
	output byte_t wbyte_o,
	output port_idx_t port_sel_o,
	input byte_t port_rdata_i
);

	logic wr_acc;
	logic rd_acc;
	logic wr_err;
	logic rd_err;
	port_idx_t wr_port;

	// Port index past the last port or register slot 3
	function automatic logic addr_err(axi_addr_t addr);
		addr_err = (addr[31:PORT_STRIDE_LSB] >= PORT_NUM) ||
			(addr[PORT_STRIDE_LSB-1:REG_IDX_LSB] > REG_CTRL);
	endfunction

	// Write wins, a read waits one cycle
	assign wr_acc = awvalid_i && wvalid_i && !bvalid_o;
	assign rd_acc = arvalid_i && !rvalid_o && !wr_acc;

	assign awready_o = wr_acc;
	assign wready_o = wr_acc;
	assign arready_o = rd_acc;

	assign wr_err = addr_err(awaddr_i);
	assign rd_err = addr_err(araddr_i);

	assign wr_port = awaddr_i[PORT_STRIDE_LSB +: $bits(port_idx_t)];
	assign port_sel_o = araddr_i[PORT_STRIDE_LSB +: $bits(port_idx_t)];

	assign reg_sel_o = wr_acc ? awaddr_i[PORT_STRIDE_LSB-1:REG_IDX_LSB] :
		araddr_i[PORT_STRIDE_LSB-1:REG_IDX_LSB];
	assign wbyte_o = wdata_i[7:0];

	always_comb begin
		wr_stb_o = '0;
		rd_stb_o = '0;
		if (wr_acc && !wr_err && wstrb_i[0]) // Upper lanes carry nothing
			wr_stb_o[wr_port] = 1'b1;
		if (rd_acc && !rd_err)
			rd_stb_o[port_sel_o] = 1'b1;
	end

	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni) begin
			bvalid_o <= 1'b0;
			rvalid_o <= 1'b0;
		end else begin
			if (wr_acc)
				bvalid_o <= 1'b1;
			else if (bready_i)
				bvalid_o <= 1'b0;
			if (rd_acc)
				rvalid_o <= 1'b1;
			else if (rready_i)
				rvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (wr_acc)
			bresp_o <= wr_err ? RESP_SLVERR : RESP_OKAY;
		if (rd_acc) begin
			rresp_o <= rd_err ? RESP_SLVERR : RESP_OKAY;
			rdata_o <= rd_err ? '0 : {24'b0, port_rdata_i}; // Sampled before the read clears
		end
	end

	a_bvalid_hold: assert property (@(posedge aclk) disable iff (!rstni)
		bvalid_o && !bready_i |=> bvalid_o);

	// One port and one direction per cycle
	a_stb_onehot: assert property (@(posedge aclk) disable iff (!rstni)
		$onehot0({wr_stb_o, rd_stb_o}));

endmodule

// ==== verilog/mps_irq_mux.sv ====
`timescale 1ns/1ps

module mps_irq_mux import mps_pkg::*; (
	input aclk,
	input rstni,
	input port_idx_t port_sel_i,
	input byte_t [PORT_NUM-1:0] rdata_i,
	input [PORT_NUM-1:0] irq_i,
	output byte_t rdata_o,
	output logic intr_request_o
);

	logic irq_any;

	// Decoder registers this byte into the R channel
	assign rdata_o = rdata_i[port_sel_i];

	assign irq_any = |irq_i;

	// One shared line for all ports
	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni)
			intr_request_o <= 1'b0;
		else
			intr_request_o <= irq_any;
	end

endmodule

// ==== verilog/mps_pkg.sv ====
package mps_pkg;

	localparam int PORT_NUM = 4;
	localparam int BAUD_DIV = 16; // Clocks per serial bit
	localparam int PORT_STRIDE_LSB = 4; // 16 bytes per port
	localparam int REG_IDX_LSB = 2; // Registers are word aligned

	typedef logic [7:0] byte_t;
	typedef logic [1:0] port_idx_t;
	typedef logic [1:0] reg_idx_t;

	typedef logic [31:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [1:0] axi_resp_t;

	typedef logic [$clog2(BAUD_DIV)-1:0] baud_cnt_t;

	// Register map inside one port
	localparam reg_idx_t REG_DATA = 2'd0; // Offset 0x0
	localparam reg_idx_t REG_STATUS = 2'd1; // Offset 0x4
	localparam reg_idx_t REG_CTRL = 2'd2; // Offset 0x8

	// STATUS bits
	localparam int ST_TX_BUSY = 0;
	localparam int ST_RX_VALID = 1;
	localparam int ST_OVERRUN = 2;

	// CTRL bits
	localparam int CT_RX_IRQ_EN = 0;
	localparam int CT_LOOPBACK = 1;

	localparam axi_resp_t RESP_OKAY = 2'd0;
	localparam axi_resp_t RESP_SLVERR = 2'd2;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage

// ==== verilog/mps_top.sv ====
`timescale 1ns/1ps

module mps_top import mps_pkg::*; (
	input aclk,
	input rstni,

	input awvalid_i,
	output logic awready_o,
	input axi_addr_t awaddr_i,
	input wvalid_i,
	output logic wready_o,
	input axi_data_t wdata_i,
	input [3:0] wstrb_i,
	output logic bvalid_o,
	input bready_i,
	output axi_resp_t bresp_o,
	input arvalid_i,
	output logic arready_o,
	input axi_addr_t araddr_i,
	output logic rvalid_o,
	input rready_i,
	output axi_data_t rdata_o,
	output axi_resp_t rresp_o,

	output logic intr_request_o,

	input [PORT_NUM-1:0] rxd_i,
	output logic [PORT_NUM-1:0] txd_o
);

	logic [PORT_NUM-1:0] wr_stb;
	logic [PORT_NUM-1:0] rd_stb;
	reg_idx_t reg_sel;
	byte_t wbyte;
	port_idx_t port_sel;
	byte_t sel_rdata;
	byte_t [PORT_NUM-1:0] port_rdata;
	logic [PORT_NUM-1:0] port_irq;

	mps_axil_regs u_regs (
		.aclk(aclk),
		.rstni(rstni),
		.awvalid_i(awvalid_i),
		.awready_o(awready_o),
		.awaddr_i(awaddr_i),
		.wvalid_i(wvalid_i),
		.wready_o(wready_o),
		.wdata_i(wdata_i),
		.wstrb_i(wstrb_i),
		.bvalid_o(bvalid_o),
		.bready_i(bready_i),
		.bresp_o(bresp_o),
		.arvalid_i(arvalid_i),
		.arready_o(arready_o),
		.araddr_i(araddr_i),
		.rvalid_o(rvalid_o),
		.rready_i(rready_i),
		.rdata_o(rdata_o),
		.rresp_o(rresp_o),
		.wr_stb_o(wr_stb),
		.rd_stb_o(rd_stb),
		.reg_sel_o(reg_sel),
		.wbyte_o(wbyte),
		.port_sel_o(port_sel),
		.port_rdata_i(sel_rdata)
	);

	for (genvar i = 0; i < PORT_NUM; i++) begin : g_port
		mps_uart_port u_port (
			.aclk(aclk),
			.rstni(rstni),
			.wr_en_i(wr_stb[i]),
			.rd_en_i(rd_stb[i]),
			.reg_sel_i(reg_sel),
			.wbyte_i(wbyte),
			.rdata_o(port_rdata[i]),
			.irq_o(port_irq[i]),
			.rxd_i(rxd_i[i]),
			.txd_o(txd_o[i])
		);
	end

	mps_irq_mux u_irq_mux (
		.aclk(aclk),
		.rstni(rstni),
		.port_sel_i(port_sel),
		.rdata_i(port_rdata),
		.irq_i(port_irq),
		.rdata_o(sel_rdata),
		.intr_request_o(intr_request_o)
	);

endmodule

// ==== verilog/mps_uart_port.sv ====
`timescale 1ns/1ps

module mps_uart_port import mps_pkg::*; (
	input aclk,
	input rstni,
	input wr_en_i,
	input rd_en_i,
	input reg_idx_t reg_sel_i,
	input byte_t wbyte_i,
	output byte_t rdata_o,
	output logic irq_o,
	input rxd_i,
	output logic txd_o
);

	tx_state_t tx_state;
	baud_cnt_t tx_cnt;
	logic [2:0] tx_bit;
	byte_t tx_shift;
	logic tx_tick;
	logic tx_start;
	logic tx_busy;

	rx_state_t rx_state;
	baud_cnt_t rx_cnt;
	logic [2:0] rx_bit;
	byte_t rx_shift;
	byte_t rx_data;
	logic [1:0] rx_sync;
	logic rx_in;
	logic rx_tick;
	logic rx_done;
	logic rx_store;
	logic rx_valid;
	logic overrun;

	logic irq_en;
	logic loopback;
	logic rd_data;

	assign tx_tick = tx_cnt == baud_cnt_t'(BAUD_DIV - 1);
	assign tx_start = wr_en_i && reg_sel_i == REG_DATA && tx_state == TX_IDLE; // Busy drops it
	assign tx_busy = tx_state != TX_IDLE;

	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni) begin
			tx_state <= TX_IDLE;
			tx_cnt <= '0;
			tx_bit <= '0;
			txd_o <= 1'b1;
		end else if (tx_start) begin
			tx_state <= TX_START;
			tx_cnt <= '0;
			txd_o <= 1'b0; // Start bit from next cycle
		end else if (tx_busy) begin
			tx_cnt <= tx_tick ? '0 : tx_cnt + 1'b1;
			if (tx_tick) begin
				case (tx_state)
					TX_START: begin
						tx_state <= TX_DATA;
						tx_bit <= '0;
						txd_o <= tx_shift[0];
					end
					TX_DATA: begin
						tx_bit <= tx_bit + 1'b1;
						if (tx_bit == 3'd7) begin
							tx_state <= TX_STOP;
							txd_o <= 1'b1;
						end else begin
							txd_o <= tx_shift[0];
						end
					end
					default: tx_state <= TX_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (tx_start)
			tx_shift <= wbyte_i;
		else if (tx_tick && (tx_state == TX_START || tx_state == TX_DATA))
			tx_shift <= tx_shift >> 1; // LSB first
	end

	// Loopback takes our own line instead of the pin
	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni)
			rx_sync <= 2'b11;
		else
			rx_sync <= {rx_sync[0], loopback ? txd_o : rxd_i};
	end
	assign rx_in = rx_sync[1];

	assign rx_tick = rx_state == RX_START ? rx_cnt == baud_cnt_t'(BAUD_DIV / 2 - 1) :
		rx_cnt == baud_cnt_t'(BAUD_DIV - 1);
	assign rx_done = rx_state == RX_STOP && rx_tick && rx_in; // Mid stop bit
	assign rd_data = rd_en_i && reg_sel_i == REG_DATA;
	assign rx_store = rx_done && (!rx_valid || rd_data);

	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni) begin
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
		end else if (rx_state == RX_IDLE) begin
			rx_cnt <= '0;
			if (!rx_in)
				rx_state <= RX_START;
		end else begin
			rx_cnt <= rx_tick ? '0 : rx_cnt + 1'b1;
			if (rx_tick) begin
				case (rx_state)
					RX_START: begin
						rx_state <= rx_in ? RX_IDLE : RX_DATA; // Glitch filter
						rx_bit <= '0;
					end
					RX_DATA: begin
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= RX_STOP;
					end
					default: rx_state <= RX_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (rx_state == RX_DATA && rx_tick)
			rx_shift <= {rx_in, rx_shift[7:1]};
		if (rx_store)
			rx_data <= rx_shift;
	end

	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni) begin
			rx_valid <= 1'b0;
			overrun <= 1'b0;
		end else if (rx_store) begin
			rx_valid <= 1'b1;
			overrun <= 1'b0;
		end else if (rx_done) begin
			overrun <= 1'b1; // Old byte kept
		end else if (rd_data) begin
			rx_valid <= 1'b0;
			overrun <= 1'b0;
		end
	end

	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni) begin
			irq_en <= 1'b0;
			loopback <= 1'b0;
		end else if (wr_en_i && reg_sel_i == REG_CTRL) begin
			irq_en <= wbyte_i[CT_RX_IRQ_EN];
			loopback <= wbyte_i[CT_LOOPBACK];
		end
	end

	always_comb begin
		rdata_o = '0;
		case (reg_sel_i)
			REG_DATA: rdata_o = rx_data;
			REG_STATUS: begin
				rdata_o[ST_TX_BUSY] = tx_busy;
				rdata_o[ST_RX_VALID] = rx_valid;
				rdata_o[ST_OVERRUN] = overrun;
			end
			REG_CTRL: begin
				rdata_o[CT_RX_IRQ_EN] = irq_en;
				rdata_o[CT_LOOPBACK] = loopback;
			end
			default: rdata_o = '0;
		endcase
	end

	assign irq_o = rx_valid && irq_en;

	a_start_low: assert property (@(posedge aclk) disable iff (!rstni)
		$rose(tx_state == TX_START) |-> !txd_o [*BAUD_DIV]);

endmodule
